// File: hdl/rvCore_params.svh
// Core width parameters
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// Data and address width, fixed by RV32I
`define WORD_WIDTH 32

// Architectural integer registers
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/rvCorePkg.sv
// RV32I core types
package rvCorePkg;

	// Base opcodes handled by the core
	typedef enum logic [6:0] {
		opcOp     = 7'b0110011,
		opcOpImm  = 7'b0010011,
		opcLoad   = 7'b0000011,
		opcStore  = 7'b0100011,
		opcBranch = 7'b1100011,
		opcJal    = 7'b1101111
	} opcodeT;

	// Zero value is add, so a bubble decodes to a harmless add
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluSlt = 3'd5
	} aluOpT;

	typedef enum logic [1:0] {
		fwdNone    = 2'd0,
		fwdFromMem = 2'd1,
		fwdFromWb  = 2'd2
	} fwdSelT;

	// One instruction word, five format views
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcodeT     opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			opcodeT      opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			opcodeT     opcode;
		} sType;
		struct packed {
			logic       imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic       imm11;
			opcodeT     opcode;
		} bType;
		struct packed {
			logic       imm20;
			logic [9:0] imm10to1;
			logic       imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			opcodeT     opcode;
		} jType;
	} instrWord;

	// Decode outputs carried down the pipe
	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrcImm;
		logic  branch;
		logic  jump;
		aluOpT aluOp;
	} ctrlT;

endpackage

// File: hdl/memPortIf.sv
// Stall-based memory port
`timescale 1ns/100ps
`include "rvCore_params.svh"

interface memPortIf;
	logic [`WORD_WIDTH-1:0] addr;
	logic ren;
	logic wen;
	logic [`WORD_WIDTH-1:0] wdata;
	// Read data is combinational in the request cycle unless stalled
	logic [`WORD_WIDTH-1:0] rdata;
	logic stall;

	modport core (
		output addr,
		output ren,
		output wen,
		output wdata,
		input  rdata,
		input  stall
	);

	modport mem (
		input  addr,
		input  ren,
		input  wen,
		input  wdata,
		output rdata,
		output stall
	);
endinterface

// File: hdl/regFile.sv
// Integer register file
`timescale 1ns/100ps
`include "rvCore_params.svh"

module regFile (
	input  logic clock,
	input  logic reset,
	input  logic [$clog2(`REG_COUNT)-1:0] readAddrA,
	input  logic [$clog2(`REG_COUNT)-1:0] readAddrB,
	input  logic [$clog2(`REG_COUNT)-1:0] writeAddr,
	input  logic writeEnable,
	input  logic [`WORD_WIDTH-1:0] writeData,
	output logic [`WORD_WIDTH-1:0] readDataA,
	output logic [`WORD_WIDTH-1:0] readDataB
);
	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];
	logic writeLive;

	// x0 is never written, so entry 0 stays zero
	assign writeLive = writeEnable && (writeAddr != '0);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeLive) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Writeback in the same cycle shows up at the read ports
	assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: hdl/immGen.sv
// Immediate extraction
`timescale 1ns/100ps
`include "rvCore_params.svh"

module immGen (
	input  rvCorePkg::instrWord instr,
	output logic [`WORD_WIDTH-1:0] imm
);
	import rvCorePkg::*;

	always_comb begin
		case (instr.rType.opcode)
			opcOpImm, opcLoad: begin
				imm = {{(`WORD_WIDTH-12){instr.iType.imm[11]}}, instr.iType.imm};
			end
			opcStore: begin
				imm = {{(`WORD_WIDTH-12){instr.sType.immHi[6]}},
					instr.sType.immHi, instr.sType.immLo};
			end
			// Branch offsets are in halfwords, bit 0 always zero
			opcBranch: begin
				imm = {{(`WORD_WIDTH-12){instr.bType.imm12}}, instr.bType.imm11,
					instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
			end
			opcJal: begin
				imm = {{(`WORD_WIDTH-20){instr.jType.imm20}}, instr.jType.imm19to12,
					instr.jType.imm11, instr.jType.imm10to1, 1'b0};
			end
			// R-type and anything unknown
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// File: hdl/controlMain.sv
// Main instruction decoder
`timescale 1ns/100ps

module controlMain (
	input  rvCorePkg::instrWord instr,
	output rvCorePkg::ctrlT ctrl
);
	import rvCorePkg::*;

	aluOpT regAluOp;

	// Register-register operation from funct3 and funct7
	always_comb begin
		case (instr.rType.funct3)
			3'b000: regAluOp = instr.rType.funct7[5] ? aluSub : aluAdd;
			3'b010: regAluOp = aluSlt;
			3'b100: regAluOp = aluXor;
			3'b110: regAluOp = aluOr;
			3'b111: regAluOp = aluAnd;
			default: regAluOp = aluAdd;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (instr.rType.opcode)
			opcOp: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = regAluOp;
			end
			opcOpImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opcLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opcStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			// Equality via the zero flag of a subtract
			opcBranch: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = aluSub;
			end
			// Link value comes from the PC in execute
			opcJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.jump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: hdl/hazardUnit.sv
// Forwarding, stall and flush control
`timescale 1ns/100ps
`include "rvCore_params.svh"

module hazardUnit (
	input  logic [$clog2(`REG_COUNT)-1:0] decodeRs1,
	input  logic [$clog2(`REG_COUNT)-1:0] decodeRs2,
	input  logic [$clog2(`REG_COUNT)-1:0] exRs1,
	input  logic [$clog2(`REG_COUNT)-1:0] exRs2,
	input  logic [$clog2(`REG_COUNT)-1:0] exRd,
	input  logic exMemRead,
	input  logic [$clog2(`REG_COUNT)-1:0] memRd,
	input  logic memRegWrite,
	input  logic [$clog2(`REG_COUNT)-1:0] wbRd,
	input  logic wbRegWrite,
	input  logic decodeJump,
	input  logic branchTaken,
	output rvCorePkg::fwdSelT fwdA,
	output rvCorePkg::fwdSelT fwdB,
	output logic pcWrite,
	output logic ifIdWrite,
	output logic ifIdFlush,
	output logic idExFlush,
	output logic exMemFlush
);
	import rvCorePkg::*;

	logic loadUse;
	logic jumpTaken;

	// Youngest producer wins, x0 is never forwarded
	function automatic fwdSelT pickFwd(input logic [$clog2(`REG_COUNT)-1:0] rs,
		input logic [$clog2(`REG_COUNT)-1:0] mRd, input logic mWrite,
		input logic [$clog2(`REG_COUNT)-1:0] wRd, input logic wWrite);
		if (mWrite && mRd != '0 && mRd == rs) begin
			return fwdFromMem;
		end else if (wWrite && wRd != '0 && wRd == rs) begin
			return fwdFromWb;
		end
		return fwdNone;
	endfunction

	assign fwdA = pickFwd(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
	assign fwdB = pickFwd(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

	// Load in execute feeding the instruction in decode
	assign loadUse = exMemRead && exRd != '0 && (exRd == decodeRs1 || exRd == decodeRs2);

	// A stalled jal waits and redirects on the next cycle
	assign jumpTaken = decodeJump && !loadUse;

	// A taken branch overrides the load-use hold
	assign pcWrite = !loadUse || branchTaken;
	assign ifIdWrite = !loadUse;
	assign ifIdFlush = jumpTaken || branchTaken;
	assign idExFlush = loadUse || branchTaken;
	assign exMemFlush = branchTaken;

endmodule

// File: hdl/alu.sv
// Integer ALU
`timescale 1ns/100ps
`include "rvCore_params.svh"

module alu (
	input  logic [`WORD_WIDTH-1:0] a,
	input  logic [`WORD_WIDTH-1:0] b,
	input  rvCorePkg::aluOpT op,
	output logic [`WORD_WIDTH-1:0] result,
	output logic zero
);
	import rvCorePkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			// Signed compare, result is 0 or 1
			aluSlt: result = {{(`WORD_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
			default: result = a + b;
		endcase
	end

	// Used by beq
	assign zero = (result == '0);

endmodule

// File: hdl/pipeline.sv
// Five-stage RV32I datapath
`timescale 1ns/100ps
`include "rvCore_params.svh"

module pipeline (
	input logic clock,
	input logic reset,
	memPortIf.core iPort,
	memPortIf.core dPort
);
	import rvCorePkg::*;

	localparam int RegAddrWidth = $clog2(`REG_COUNT);

	// Fetch
	logic fetchEnable;
	logic [`WORD_WIDTH-1:0] pc, nextPc, jalTarget;
	logic freeze;

	// IF/ID
	instrWord ifIdInstr;
	logic [`WORD_WIDTH-1:0] ifIdPc;

	// Decode
	ctrlT idCtrl;
	logic [`WORD_WIDTH-1:0] idImm, rfDataA, rfDataB;
	logic [RegAddrWidth-1:0] idRs1, idRs2;

	// ID/EX
	ctrlT idExCtrl;
	logic [`WORD_WIDTH-1:0] idExPc, idExDataA, idExDataB, idExImm;
	logic [RegAddrWidth-1:0] idExRs1, idExRs2, idExRd;

	// Execute
	fwdSelT fwdA, fwdB;
	logic [`WORD_WIDTH-1:0] exOpA, exOpB, exAluB, exAluResult, exResult;
	logic exZero;

	// EX/MEM
	ctrlT exMemCtrl;
	logic [`WORD_WIDTH-1:0] exMemResult, exMemStoreData, exMemBranchTarget;
	logic exMemZero;
	logic [RegAddrWidth-1:0] exMemRd;
	logic branchTaken;

	// MEM/WB
	ctrlT memWbCtrl;
	logic [`WORD_WIDTH-1:0] memWbResult, memWbLoadData, wbData;
	logic [RegAddrWidth-1:0] memWbRd;

	// Hazard control
	logic pcWrite, ifIdWrite, ifIdFlush, idExFlush, exMemFlush;

	// Either port stalling holds the whole pipe
	assign freeze = iPort.stall || dPort.stall;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			fetchEnable <= 1'b0;
		end else begin
			fetchEnable <= 1'b1;
		end
	end

	// Branch in memory is older than a jal in decode
	assign jalTarget = ifIdPc + idImm;
	assign nextPc = branchTaken ? exMemBranchTarget :
		idCtrl.jump ? jalTarget : pc + `WORD_WIDTH'd4;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `RESET_PC;
		end else if (fetchEnable && !freeze && pcWrite) begin
			pc <= nextPc;
		end
	end

	assign iPort.addr = pc;
	assign iPort.ren = fetchEnable;
	assign iPort.wen = 1'b0;
	assign iPort.wdata = '0;

	// An all-zero instruction word decodes as a bubble
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifIdInstr <= '0;
		end else if (!freeze) begin
			if (ifIdFlush) begin
				ifIdInstr <= '0;
			end else if (ifIdWrite) begin
				ifIdInstr <= fetchEnable ? iPort.rdata : '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze && ifIdWrite) begin
			ifIdPc <= pc;
		end
	end

	controlMain u_controlMain (
		.instr(ifIdInstr),
		.ctrl(idCtrl)
	);

	immGen u_immGen (
		.instr(ifIdInstr),
		.imm(idImm)
	);

	regFile u_regFile (
		.clock(clock),
		.reset(reset),
		.readAddrA(ifIdInstr.rType.rs1),
		.readAddrB(ifIdInstr.rType.rs2),
		.writeAddr(memWbRd),
		.writeEnable(memWbCtrl.regWrite),
		.writeData(wbData),
		.readDataA(rfDataA),
		.readDataB(rfDataB)
	);

	// Source fields that the format does not use read as x0
	assign idRs1 = idCtrl.jump ? '0 : ifIdInstr.rType.rs1;
	assign idRs2 = (idCtrl.jump || (idCtrl.aluSrcImm && !idCtrl.memWrite)) ?
		'0 : ifIdInstr.rType.rs2;

	hazardUnit u_hazardUnit (
		.decodeRs1(idRs1),
		.decodeRs2(idRs2),
		.exRs1(idExRs1),
		.exRs2(idExRs2),
		.exRd(idExRd),
		.exMemRead(idExCtrl.memRead),
		.memRd(exMemRd),
		.memRegWrite(exMemCtrl.regWrite),
		.wbRd(memWbRd),
		.wbRegWrite(memWbCtrl.regWrite),
		.decodeJump(idCtrl.jump),
		.branchTaken(branchTaken),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.pcWrite(pcWrite),
		.ifIdWrite(ifIdWrite),
		.ifIdFlush(ifIdFlush),
		.idExFlush(idExFlush),
		.exMemFlush(exMemFlush)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			idExCtrl <= '0;
		end else if (!freeze) begin
			if (idExFlush) begin
				idExCtrl <= '0;
			end else begin
				idExCtrl <= idCtrl;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			idExPc <= ifIdPc;
			idExDataA <= rfDataA;
			idExDataB <= rfDataB;
			idExImm <= idImm;
			idExRs1 <= idRs1;
			idExRs2 <= idRs2;
			idExRd <= ifIdInstr.rType.rd;
		end
	end

	// Operand forwarding
	assign exOpA = (fwdA == fwdFromMem) ? exMemResult :
		(fwdA == fwdFromWb) ? wbData : idExDataA;
	assign exOpB = (fwdB == fwdFromMem) ? exMemResult :
		(fwdB == fwdFromWb) ? wbData : idExDataB;
	assign exAluB = idExCtrl.aluSrcImm ? idExImm : exOpB;

	alu u_alu (
		.a(exOpA),
		.b(exAluB),
		.op(idExCtrl.aluOp),
		.result(exAluResult),
		.zero(exZero)
	);

	// jal links the return address
	assign exResult = idExCtrl.jump ? idExPc + `WORD_WIDTH'd4 : exAluResult;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exMemCtrl <= '0;
		end else if (!freeze) begin
			if (exMemFlush) begin
				exMemCtrl <= '0;
			end else begin
				exMemCtrl <= idExCtrl;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			exMemResult <= exResult;
			exMemStoreData <= exOpB;
			exMemBranchTarget <= idExPc + idExImm;
			exMemZero <= exZero;
			exMemRd <= idExRd;
		end
	end

	assign branchTaken = exMemCtrl.branch && exMemZero;

	assign dPort.addr = exMemResult;
	assign dPort.ren = exMemCtrl.memRead;
	assign dPort.wen = exMemCtrl.memWrite;
	assign dPort.wdata = exMemStoreData;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memWbCtrl <= '0;
		end else if (!freeze) begin
			memWbCtrl <= exMemCtrl;
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			memWbResult <= exMemResult;
			memWbLoadData <= dPort.rdata;
			memWbRd <= exMemRd;
		end
	end

	assign wbData = memWbCtrl.memToReg ? memWbLoadData : memWbResult;

endmodule

// File: hdl/rvCoreTop.sv
// RV32I core top level
`timescale 1ns/100ps
`include "rvCore_params.svh"

module rvCoreTop (
	input  logic clock,
	input  logic reset,
	input  logic iStall,
	input  rvCorePkg::instrWord iRdata,
	output logic [`WORD_WIDTH-1:0] iAddr,
	output logic iRen,
	input  logic dStall,
	input  logic [`WORD_WIDTH-1:0] dRdata,
	output logic [`WORD_WIDTH-1:0] dAddr,
	output logic dRen,
	output logic dWen,
	output logic [`WORD_WIDTH-1:0] dWdata
);
	memPortIf iPort ();
	memPortIf dPort ();

	pipeline u_pipeline (
		.clock(clock),
		.reset(reset),
		.iPort(iPort.core),
		.dPort(dPort.core)
	);

	// Instruction side is read-only
	assign iAddr = iPort.addr;
	assign iRen = iPort.ren;
	assign iPort.rdata = iRdata;
	assign iPort.stall = iStall;

	assign dAddr = dPort.addr;
	assign dRen = dPort.ren;
	assign dWen = dPort.wen;
	assign dWdata = dPort.wdata;
	assign dPort.rdata = dRdata;
	assign dPort.stall = dStall;

endmodule

// File: sim/rvCore_checker.sv
// Memory port assertions
`timescale 1ns/100ps
`include "rvCore_params.svh"

module rvCoreChecker (
	input logic clock,
	input logic reset,
	input logic iStall,
	input logic dStall,
	input logic [`WORD_WIDTH-1:0] iAddr,
	input logic iRen,
	input logic [`WORD_WIDTH-1:0] dAddr,
	input logic dRen,
	input logic dWen,
	input logic [`WORD_WIDTH-1:0] dWdata
);

	// One data access per cycle
	readWriteExclusive: assert property (@(posedge clock) disable iff (!reset)
		!(dRen && dWen))
		else $error("dRen and dWen are high in the same cycle");

	strobesLowInReset: assert property (@(posedge clock)
		!reset |-> (!iRen && !dRen && !dWen))
		else $error("a request strobe is high while reset is asserted");

	// A stalled request is held unchanged
	stallHoldsRequest: assert property (@(posedge clock) disable iff (!reset)
		(iStall || dStall) |=> ($stable(iAddr) && $stable(iRen) && $stable(dAddr)
		&& $stable(dRen) && $stable(dWen) && $stable(dWdata)))
		else $error("a port request changed while a stall was high");

endmodule

bind rvCoreTop rvCoreChecker u_rvCoreChecker (.*);

// File: sim/rvCoreTb.sv
// RV32I core testbench
`timescale 1ns/100ps
`include "rvCore_params.svh"

module rvCoreTb;
	localparam int MemWords = 64;
	localparam int WaitLimit = 2000;
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	logic clock = 1'b1;
	logic reset = 1'b1;
	logic iStall = 1'b0;
	logic [`WORD_WIDTH-1:0] iRdata = '0;
	logic [`WORD_WIDTH-1:0] iAddr;
	logic iRen;
	logic dStall = 1'b0;
	logic [`WORD_WIDTH-1:0] dRdata = '0;
	logic [`WORD_WIDTH-1:0] dAddr;
	logic dRen;
	logic dWen;
	logic [`WORD_WIDTH-1:0] dWdata;

	logic [31:0] imem [MemWords];
	logic [31:0] dmem [MemWords];
	logic [31:0] refMem [MemWords];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] haltPc = '1;
	logic stallsOn = 1'b0;
	logic stallRun = 1'b0;
	int storeIndex = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors [1:5] = '{default: 0};

	rvCoreTop u_rvCoreTop (
		.clock(clock),
		.reset(reset),
		.iStall(iStall),
		.iRdata(iRdata),
		.iAddr(iAddr),
		.iRen(iRen),
		.dStall(dStall),
		.dRdata(dRdata),
		.dAddr(dAddr),
		.dRen(dRen),
		.dWen(dWen),
		.dWdata(dWdata)
	);

	always #20 clock = ~clock;

	// Instruction encoders
	function automatic logic [31:0] regOp(input logic [6:0] funct7, input logic [2:0] funct3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {funct7, rs2, rs1, funct3, rd, opReg};
	endfunction

	function automatic logic [31:0] immOp(input logic [6:0] opc, input logic [2:0] funct3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, opc};
	endfunction

	function automatic logic [31:0] storeOp(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] beqOp(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jalOp(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// Initial data memory contents
	function automatic logic [31:0] fillWord(input int idx);
		return 32'h5A00_0000 ^ (idx * 32'h0001_0203);
	endfunction

	// Stores to 0x40, 0x80 and 0xC0 belong to tests 2, 3 and 4
	function automatic int testOfAddr(input logic [31:0] addr);
		case (addr[7:6])
			2'd2: return 3;
			2'd3: return 4;
			default: return 2;
		endcase
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < MemWords; i++) begin
			imem[i] = '0;
		end
		// Dependent ALU chain, then its results stored at 0x40
		imem[0] = immOp(opImm, 3'b000, 5'd1, 5'd0, 12'd5);
		imem[1] = immOp(opImm, 3'b000, 5'd2, 5'd0, -12'sd3);
		imem[2] = regOp(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
		imem[3] = regOp(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
		imem[4] = regOp(7'h00, 3'b111, 5'd5, 5'd4, 5'd1);
		imem[5] = regOp(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);
		imem[6] = regOp(7'h00, 3'b100, 5'd7, 5'd6, 5'd3);
		imem[7] = regOp(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
		imem[8] = regOp(7'h00, 3'b010, 5'd9, 5'd1, 5'd7);
		imem[9] = immOp(opImm, 3'b000, 5'd10, 5'd0, 12'd64);
		imem[10] = storeOp(5'd3, 5'd10, 12'd0);
		imem[11] = storeOp(5'd4, 5'd10, 12'd4);
		imem[12] = storeOp(5'd5, 5'd10, 12'd8);
		imem[13] = storeOp(5'd6, 5'd10, 12'd12);
		imem[14] = storeOp(5'd7, 5'd10, 12'd16);
		imem[15] = storeOp(5'd8, 5'd10, 12'd20);
		imem[16] = storeOp(5'd9, 5'd10, 12'd24);
		// Load-use pairs at 0x80
		imem[17] = immOp(opImm, 3'b000, 5'd11, 5'd0, 12'd128);
		imem[18] = immOp(opLoad, 3'b010, 5'd12, 5'd11, 12'd0);
		imem[19] = regOp(7'h00, 3'b000, 5'd13, 5'd12, 5'd1);
		imem[20] = storeOp(5'd13, 5'd11, 12'd4);
		imem[21] = immOp(opLoad, 3'b010, 5'd14, 5'd11, 12'd4);
		imem[22] = storeOp(5'd14, 5'd11, 12'd8);
		// Branches and jal at 0xC0, squashed stores in between
		imem[23] = immOp(opImm, 3'b000, 5'd15, 5'd0, 12'd192);
		imem[24] = beqOp(5'd1, 5'd2, 13'd8);
		imem[25] = storeOp(5'd1, 5'd15, 12'd0);
		imem[26] = beqOp(5'd3, 5'd3, 13'd16);
		imem[27] = storeOp(5'd2, 5'd15, 12'd4);
		imem[28] = storeOp(5'd3, 5'd15, 12'd8);
		imem[29] = storeOp(5'd4, 5'd15, 12'd12);
		imem[30] = storeOp(5'd5, 5'd15, 12'd16);
		imem[31] = jalOp(5'd16, 21'd12);
		imem[32] = storeOp(5'd6, 5'd15, 12'd20);
		imem[33] = storeOp(5'd7, 5'd15, 12'd24);
		imem[34] = storeOp(5'd16, 5'd15, 12'd28);
		// Jump to self ends the program
		imem[35] = jalOp(5'd0, 21'd0);
	endtask

	// Instruction-level model of the program
	function automatic void runReference();
		logic [31:0] regs [32];
		logic [31:0] pc, nextPc, instr, a, b, addr, result;
		logic [31:0] immI, immS, immB, immJ;
		logic writeRd;
		logic halted;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MemWords; i++) begin
			refMem[i] = fillWord(i);
		end
		expAddr.delete();
		expData.delete();
		pc = `RESET_PC;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 500) begin
			instr = imem[pc[7:2]];
			a = regs[instr[19:15]];
			b = regs[instr[24:20]];
			immI = {{20{instr[31]}}, instr[31:20]};
			immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			nextPc = pc + 32'd4;
			writeRd = 1'b0;
			result = '0;
			case (instr[6:0])
				opReg: begin
					writeRd = 1'b1;
					case (instr[14:12])
						3'b000: result = instr[30] ? a - b : a + b;
						// Signs differ means the negative one is smaller
						3'b010: result = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
						3'b100: result = a ^ b;
						3'b110: result = a | b;
						default: result = a & b;
					endcase
				end
				opImm: begin
					writeRd = 1'b1;
					result = a + immI;
				end
				opLoad: begin
					writeRd = 1'b1;
					addr = a + immI;
					result = refMem[addr[7:2]];
				end
				opStore: begin
					addr = a + immS;
					refMem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				opBranch: begin
					if (a == b) begin
						nextPc = pc + immB;
					end
				end
				opJal: begin
					if (immJ == '0) begin
						halted = 1'b1;
						haltPc = pc;
					end
					writeRd = 1'b1;
					result = pc + 32'd4;
					nextPc = pc + immJ;
				end
				default: begin
					writeRd = 1'b0;
				end
			endcase
			if (writeRd && instr[11:7] != 5'd0) begin
				regs[instr[11:7]] = result;
			end
			pc = nextPc;
			steps++;
		end
	endfunction

	task automatic checkValue(input int testId, input logic [31:0] actual,
		input logic [31:0] expected, input string what);
		checkCount++;
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
			testErrors[testId]++;
		end
	endtask

	task automatic abortRun(input string reason);
		$display("Timeout: %s", reason);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic reportTest(input int id, input string name);
		$display("Test %0d %s: %s (%0d errors)", id, name,
			(testErrors[id] == 0) ? "passed" : "failed", testErrors[id]);
	endtask

	// Reset for 10 cycles with data memory reloaded
	task automatic resetCore();
		@(negedge clock);
		reset = 1'b0;
		stallsOn = 1'b0;
		storeIndex = 0;
		for (int i = 0; i < MemWords; i++) begin
			dmem[i] = fillWord(i);
		end
		repeat (10) @(negedge clock);
		checkValue(1, {29'd0, iRen, dRen, dWen}, '0, "request strobes in reset");
		reset = 1'b1;
	endtask

	task automatic waitForFetch();
		int cycles;
		cycles = 0;
		while (iRen !== 1'b1) begin
			if (cycles >= WaitLimit) begin
				abortRun("the core never started fetching after reset");
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic waitForStores();
		int cycles;
		cycles = 0;
		while (storeIndex < expAddr.size()) begin
			if (cycles >= WaitLimit) begin
				abortRun("the core stopped before making all expected stores");
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic waitForHalt();
		int cycles;
		cycles = 0;
		while (iAddr !== haltPc) begin
			if (cycles >= WaitLimit) begin
				abortRun("the core never reached the final jump");
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic compareMemory();
		for (int i = 0; i < MemWords; i++) begin
			checkValue(stallRun ? 5 : testOfAddr(i * 4), dmem[i], refMem[i],
				$sformatf("data memory word %0d", i));
		end
	endtask

	// Inputs change on the falling edge
	always @(negedge clock) begin
		iRdata <= imem[iAddr[7:2]];
		// Read data only while a load is requested
		dRdata <= dRen ? dmem[dAddr[7:2]] : 'x;
	end

	// Random stalls on either port, about one cycle in four
	initial begin
		int pick;
		pick = $urandom(29);
		forever begin
			@(negedge clock);
			pick = $urandom % 8;
			iStall <= stallsOn && (pick == 0);
			dStall <= stallsOn && (pick == 1);
		end
	end

	// Data memory model, a write lands when neither port stalls
	always @(posedge clock) begin
		if (reset && dWen && !dStall && !iStall) begin
			dmem[dAddr[7:2]] <= dWdata;
		end
	end

	// Every accepted store is checked against the next reference entry
	always @(posedge clock) begin
		int testId;
		if (reset && dWen && !dStall && !iStall) begin
			if (storeIndex < expAddr.size()) begin
				testId = stallRun ? 5 : testOfAddr(expAddr[storeIndex]);
				checkValue(testId, dAddr, expAddr[storeIndex], "store address");
				checkValue(testId, dWdata, expData[storeIndex], "store data");
			end else begin
				$display("Extra store at time %0t to address %h after the last expected one",
					$time, dAddr);
				errorCount++;
				testErrors[stallRun ? 5 : 4]++;
			end
			storeIndex++;
		end
	end

	initial begin
		loadProgram();
		runReference();

		resetCore();
		waitForFetch();
		checkValue(1, iAddr, `RESET_PC, "first fetch address");
		reportTest(1, "reset state and first fetch");

		waitForStores();
		waitForHalt();
		compareMemory();
		reportTest(2, "dependent ALU chain with forwarding");
		reportTest(3, "load-use stall");
		reportTest(4, "beq and jal redirects");

		// Same program with random stalls on both ports
		stallRun = 1'b1;
		resetCore();
		waitForFetch();
		@(posedge clock);
		stallsOn = 1'b1;
		waitForStores();
		waitForHalt();
		stallsOn = 1'b0;
		compareMemory();
		reportTest(5, "full program with random stalls");

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+hdl
hdl/rvCorePkg.sv
hdl/memPortIf.sv
hdl/regFile.sv
hdl/immGen.sv
hdl/controlMain.sv
hdl/hazardUnit.sv
hdl/alu.sv
hdl/pipeline.sv
hdl/rvCoreTop.sv
sim/rvCore_checker.sv
sim/rvCoreTb.sv
